// ==== mem_bridge.f ====
verilog/mem_bridge_pkg.sv
verilog/req_decode.sv
verilog/port_arbiter.sv
verilog/axi_txn_engine.sv
verilog/rsp_return.sv
verilog/mem_bridge_top.sv
verif/tb_clock.sv
verif/axi_mem_model.sv
verif/mem_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_bridge_tb -f mem_bridge.f -o mem_bridge_sim
status=$?
if [ $status -ne 0 ]; then
    echo "compile step failed with status $status"
    exit 1
fi

./obj_dir/mem_bridge_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== verif/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model
    import mem_bridge_pkg::*;
(
    input  logic    aclk,
    input  logic    aresetn,
    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,
    output axi_r_t  r,
    output logic    rvalid,
    input  logic    rready,
    input  axi_aw_t aw,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    output axi_b_t  b,
    output logic    bvalid,
    input  logic    bready,
    output addr_t   last_ar_addr,
    output axi_id_t last_ar_id,
    output addr_t   last_aw_addr,
    output axi_id_t last_aw_id
);

    data_t       mem [addr_t];
    logic [31:0] rnd;
    logic [1:0]  ar_wait;
    logic [1:0]  r_wait;
    logic [1:0]  aw_wait;
    logic [1:0]  w_wait;
    logic [1:0]  b_wait;
    logic        rd_busy;
    logic        aw_got;
    logic        w_got;
    axi_w_t      w_q;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // untouched words hold a pattern of their own address
    function automatic data_t read_word(input addr_t a);
        addr_t wa;
        wa = {a[31:2], 2'b00};
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return wa ^ 32'ha5a5_5a5a;
    endfunction

    // error window only answers data accesses, the boot window overlaps it
    function automatic logic in_err(input addr_t a, input axi_id_t id);
        return (a[28:24] == 5'h1f) && (id == DATA_ID);
    endfunction

    task automatic write_word(input addr_t a, input axi_w_t wd);
        data_t word;
        addr_t wa;
        int    i;
        wa = {a[31:2], 2'b00};
        word = read_word(wa);
        for (i = 0; i < STRB_W; i++) begin
            if (wd.strb[i]) begin
                word[8*i +: 8] = wd.data[8*i +: 8];
            end
        end
        mem[wa] = word;
    endtask

    always @(posedge aclk) begin
        if (!aresetn) begin
            rnd <= 32'h5ba3dae8;
            arready <= 1'b0;
            rvalid <= 1'b0;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            r <= '0;
            b <= '0;
            rd_busy <= 1'b0;
            aw_got <= 1'b0;
            w_got <= 1'b0;
            ar_wait <= '0;
            r_wait <= '0;
            aw_wait <= '0;
            w_wait <= '0;
            b_wait <= '0;
            last_ar_addr <= '0;
            last_ar_id <= '0;
            last_aw_addr <= '0;
            last_aw_id <= '0;
        end else begin
            rnd <= lcg_next(rnd);

            arready <= 1'b0;
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                r_wait <= rnd[19:18];
                ar_wait <= rnd[17:16];
                last_ar_addr <= ar.addr;
                last_ar_id <= ar.id;
                r.id <= ar.id;
                r.last <= 1'b1;
                if (in_err(ar.addr, ar.id)) begin
                    r.data <= '0;
                    // slverr
                    r.resp <= 2'b10;
                end else begin
                    r.data <= read_word(ar.addr);
                    r.resp <= RESP_OKAY;
                end
            end else if (arvalid && !rd_busy) begin
                if (ar_wait == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1'b1;
                end
            end

            if (rd_busy && !rvalid) begin
                if (r_wait == 0) begin
                    rvalid <= 1'b1;
                end else begin
                    r_wait <= r_wait - 1'b1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                rd_busy <= 1'b0;
            end

            awready <= 1'b0;
            if (awvalid && awready) begin
                aw_got <= 1'b1;
                aw_wait <= rnd[21:20];
                last_aw_addr <= aw.addr;
                last_aw_id <= aw.id;
            end else if (awvalid && !aw_got) begin
                if (aw_wait == 0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 1'b1;
                end
            end

            wready <= 1'b0;
            if (wvalid && wready) begin
                w_got <= 1'b1;
                w_q <= w;
                w_wait <= rnd[23:22];
            end else if (wvalid && !w_got) begin
                if (w_wait == 0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 1'b1;
                end
            end

            // memory is updated when the b response goes out
            if (aw_got && w_got && !bvalid) begin
                if (b_wait == 0) begin
                    bvalid <= 1'b1;
                    b.id <= last_aw_id;
                    aw_got <= 1'b0;
                    w_got <= 1'b0;
                    b_wait <= rnd[25:24];
                    if (in_err(last_aw_addr, last_aw_id)) begin
                        b.resp <= 2'b10;
                    end else begin
                        b.resp <= RESP_OKAY;
                        write_word(last_aw_addr, w_q);
                    end
                end else begin
                    b_wait <= b_wait - 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== verif/mem_bridge_tb.sv ====
`timescale 1ns/1ps

module mem_bridge_tb
    import mem_bridge_pkg::*;
();

    localparam int N_TESTS = 12;
    localparam int WATCHDOG_CYCLES = N_TESTS * 64;

    typedef struct packed {
        logic       port;
        logic       write;
        addr_t      vaddr;
        strb_t      strb;
        data_t      wdata;
        data_t      exp_rdata;
        logic       exp_err;
        addr_t      exp_paddr;
        logic       pair;
        logic [3:0] stall;
    } test_t;

    logic     aclk;
    logic     aresetn;
    mem_req_t inst_req;
    logic     inst_req_valid;
    logic     inst_req_ready;
    mem_rsp_t inst_rsp;
    logic     inst_rsp_valid;
    logic     inst_rsp_ready;
    mem_req_t data_req;
    logic     data_req_valid;
    logic     data_req_ready;
    mem_rsp_t data_rsp;
    logic     data_rsp_valid;
    logic     data_rsp_ready;
    axi_ar_t  ar;
    logic     arvalid;
    logic     arready;
    axi_r_t   r;
    logic     rvalid;
    logic     rready;
    axi_aw_t  aw;
    logic     awvalid;
    logic     awready;
    axi_w_t   w;
    logic     wvalid;
    logic     wready;
    axi_b_t   b;
    logic     bvalid;
    logic     bready;
    addr_t    last_ar_addr;
    axi_id_t  last_ar_id;
    addr_t    last_aw_addr;
    axi_id_t  last_aw_id;

    test_t    tests [N_TESTS];
    string    names [N_TESTS];
    int       n_added;
    int       n_pass;
    int       n_fail;

    tb_clock u_clock (.*);

    mem_bridge_top DUT (.*);

    axi_mem_model u_mem (.*);

    task automatic add_entry(input string nm, input logic port, input logic write,
                             input addr_t vaddr, input strb_t strb, input data_t wdata,
                             input data_t exp_rdata, input logic exp_err,
                             input addr_t exp_paddr, input logic pair, input logic [3:0] stall);
        names[n_added] = nm;
        tests[n_added] = '{port, write, vaddr, strb, wdata, exp_rdata, exp_err,
                           exp_paddr, pair, stall};
        n_added++;
    endtask

    task automatic fill_table();
        // name, port (1 = data), write, vaddr, strb, wdata
        //   expected rdata, err, paddr, launched with next entry, rsp_ready hold cycles
        add_entry("inst_boot", 1'b0, 1'b0, 32'hbfc0_0000, 4'h0, 32'h0,
                  32'hba65_5a5a, 1'b0, 32'h1fc0_0000, 1'b0, 4'd0);
        add_entry("data_write_strb", 1'b1, 1'b1, 32'h8000_1000, 4'h5, 32'h1122_3344,
                  32'h0, 1'b0, 32'h0000_1000, 1'b0, 4'd0);
        add_entry("data_read_back", 1'b1, 1'b0, 32'ha000_1000, 4'h0, 32'h0,
                  32'ha522_4a44, 1'b0, 32'h0000_1000, 1'b0, 4'd0);
        add_entry("data_read_err", 1'b1, 1'b0, 32'hbf00_0010, 4'h0, 32'h0,
                  32'h0, 1'b1, 32'h1f00_0010, 1'b0, 4'd0);
        add_entry("data_write_err", 1'b1, 1'b1, 32'h9f80_0020, 4'hf, 32'hdead_beef,
                  32'h0, 1'b1, 32'h1f80_0020, 1'b0, 4'd0);
        add_entry("pair_inst_read", 1'b0, 1'b0, 32'h8000_0040, 4'h0, 32'h0,
                  32'ha5a5_5a1a, 1'b0, 32'h0000_0040, 1'b1, 4'd0);
        add_entry("pair_data_read", 1'b1, 1'b0, 32'h0000_2000, 4'h0, 32'h0,
                  32'ha5a5_7a5a, 1'b0, 32'h0000_2000, 1'b0, 4'd0);
        add_entry("pair_inst_alias", 1'b0, 1'b0, 32'ha000_1000, 4'h0, 32'h0,
                  32'ha522_4a44, 1'b0, 32'h0000_1000, 1'b1, 4'd0);
        add_entry("pair_data_write", 1'b1, 1'b1, 32'h8000_3000, 4'hf, 32'hcafe_f00d,
                  32'h0, 1'b0, 32'h0000_3000, 1'b0, 4'd0);
        add_entry("held_data_read", 1'b1, 1'b0, 32'h8000_3000, 4'h0, 32'h0,
                  32'hcafe_f00d, 1'b0, 32'h0000_3000, 1'b0, 4'd6);
        add_entry("after_held_read", 1'b1, 1'b0, 32'h8000_2004, 4'h0, 32'h0,
                  32'ha5a5_7a5e, 1'b0, 32'h0000_2004, 1'b0, 4'd0);
        add_entry("held_inst_read", 1'b0, 1'b0, 32'hbfc0_0004, 4'h0, 32'h0,
                  32'hba65_5a5e, 1'b0, 32'h1fc0_0004, 1'b0, 4'd4);
    endtask

    function automatic mem_req_t build_req(input test_t t);
        mem_req_t rq;
        rq.addr = t.vaddr;
        rq.write = t.write;
        rq.size = SIZE_WORD;
        rq.strb = t.strb;
        rq.wdata = t.wdata;
        return rq;
    endfunction

    task automatic drive_req(input logic p, input mem_req_t rq, input logic v);
        if (p) begin
            data_req <= rq;
            data_req_valid <= v;
        end else begin
            inst_req <= rq;
            inst_req_valid <= v;
        end
    endtask

    task automatic set_rsp_ready(input logic p, input logic v);
        if (p) begin
            data_rsp_ready <= v;
        end else begin
            inst_rsp_ready <= v;
        end
    endtask

    function automatic logic req_ready_of(input logic p);
        return p ? data_req_ready : inst_req_ready;
    endfunction

    function automatic logic rsp_valid_of(input logic p);
        return p ? data_rsp_valid : inst_rsp_valid;
    endfunction

    function automatic logic rsp_ready_of(input logic p);
        return p ? data_rsp_ready : inst_rsp_ready;
    endfunction

    function automatic mem_rsp_t rsp_of(input logic p);
        return p ? data_rsp : inst_rsp;
    endfunction

    function automatic bit compare_value(input string nm, input string what,
                                         input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Fail %s %s expected %h actual %h", nm, what, exp, act);
        end
        return exp === act;
    endfunction

    task automatic record_result(input string nm, input bit ok);
        if (ok) begin
            n_pass++;
            $display("%s: ok", nm);
        end else begin
            n_fail++;
            $display("%s: errors", nm);
        end
    endtask

    task automatic check_reset();
        bit ok;
        ok = 1'b1;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        assert (!inst_rsp_valid && !data_rsp_valid && !arvalid && !awvalid && !wvalid)
        else begin
            $display("reset_state: a valid output is high while reset is applied");
            ok = 1'b0;
        end
        while (!aresetn) @(negedge aclk);
        assert (!inst_rsp_valid && !data_rsp_valid && !arvalid && !awvalid && !wvalid &&
                !rready && !bready)
        else begin
            $display("reset_state: a valid or ready output is high right after reset");
            ok = 1'b0;
        end
        assert (inst_req_ready && data_req_ready) else begin
            $display("reset_state: a request port is not ready after reset");
            ok = 1'b0;
        end
        record_result("reset_state", ok);
    endtask

    // one entry, or two entries on different ports launched in the same cycle
    task automatic run_group(input int first, input int cnt);
        int       e;
        int       k;
        logic     p;
        bit       ok [2];
        bit       sent [2];
        bit       got [2];
        bit       seen [2];
        bit       fire [2];
        int       held [2];
        mem_rsp_t rsp_seen [2];
        addr_t    addr_seen [2];
        axi_id_t  id_seen [2];
        @(posedge aclk);
        for (k = 0; k < cnt; k++) begin
            e = first + k;
            ok[k] = 1'b1;
            sent[k] = 1'b0;
            got[k] = 1'b0;
            seen[k] = 1'b0;
            held[k] = 0;
            drive_req(tests[e].port, build_req(tests[e]), 1'b1);
            set_rsp_ready(tests[e].port, tests[e].stall == 0);
        end
        while (!(got[0] && (cnt == 1 || got[1]))) begin
            @(negedge aclk);
            for (k = 0; k < cnt; k++) begin
                e = first + k;
                p = tests[e].port;
                fire[k] = !sent[k] && req_ready_of(p);
                if (got[k]) begin
                    assert (!rsp_valid_of(p)) else begin
                        $display("%s: a second response came back on its port", names[e]);
                        ok[k] = 1'b0;
                    end
                end else if (rsp_valid_of(p)) begin
                    if (!seen[k]) begin
                        seen[k] = 1'b1;
                        rsp_seen[k] = rsp_of(p);
                        addr_seen[k] = tests[e].write ? last_aw_addr : last_ar_addr;
                        id_seen[k] = tests[e].write ? last_aw_id : last_ar_id;
                    end
                    assert (rsp_of(p) == rsp_seen[k]) else begin
                        $display("%s: response changed while it was held", names[e]);
                        ok[k] = 1'b0;
                    end
                    if (rsp_ready_of(p)) begin
                        got[k] = 1'b1;
                    end else begin
                        held[k]++;
                    end
                end else begin
                    assert (!seen[k]) else begin
                        $display("%s: response valid dropped before it was taken", names[e]);
                        ok[k] = 1'b0;
                        got[k] = 1'b1;
                    end
                end
            end
            @(posedge aclk);
            for (k = 0; k < cnt; k++) begin
                e = first + k;
                p = tests[e].port;
                if (fire[k]) begin
                    drive_req(p, '0, 1'b0);
                    sent[k] = 1'b1;
                end
                if (seen[k] && !got[k] && held[k] >= tests[e].stall) begin
                    set_rsp_ready(p, 1'b1);
                end
            end
        end
        @(negedge aclk);
        for (k = 0; k < cnt; k++) begin
            e = first + k;
            p = tests[e].port;
            assert (!rsp_valid_of(p)) else begin
                $display("%s: response was delivered more than once", names[e]);
                ok[k] = 1'b0;
            end
            if (!tests[e].write && !compare_value(names[e], "rdata", tests[e].exp_rdata,
                                                  rsp_seen[k].rdata)) begin
                ok[k] = 1'b0;
            end
            if (!compare_value(names[e], "err", tests[e].exp_err, rsp_seen[k].err)) begin
                ok[k] = 1'b0;
            end
            if (!compare_value(names[e], "paddr", tests[e].exp_paddr, addr_seen[k])) begin
                ok[k] = 1'b0;
            end
            if (!compare_value(names[e], "id", p ? DATA_ID : INST_ID, id_seen[k])) begin
                ok[k] = 1'b0;
            end
            record_result(names[e], ok[k]);
        end
    endtask

    initial begin
        int i;
        inst_req = '0;
        inst_req_valid = 1'b0;
        inst_rsp_ready = 1'b1;
        data_req = '0;
        data_req_valid = 1'b0;
        data_rsp_ready = 1'b1;
        n_added = 0;
        n_pass = 0;
        n_fail = 0;
        fill_table();
        check_reset();
        i = 0;
        while (i < N_TESTS) begin
            if (tests[i].pair) begin
                run_group(i, 2);
                i = i + 2;
            end else begin
                run_group(i, 1);
                i = i + 1;
            end
        end
        $display("%0d tests, %0d ok, %0d with errors", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic aclk,
    output logic aresetn
);

    // 8 ns period
    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    initial begin
        aresetn = 1'b0;
        repeat (5) @(posedge aclk);
        aresetn <= 1'b1;
    end

endmodule

// ==== verilog/axi_txn_engine.sv ====
`timescale 1ns/1ps

module axi_txn_engine
    import mem_bridge_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  dec_req_t  req,
    input  logic      req_valid,
    output logic      req_ready,
    output axi_ar_t   ar,
    output logic      arvalid,
    input  logic      arready,
    input  axi_r_t    r,
    input  logic      rvalid,
    output logic      rready,
    output axi_aw_t   aw,
    output logic      awvalid,
    input  logic      awready,
    output axi_w_t    w,
    output logic      wvalid,
    input  logic      wready,
    input  axi_b_t    b,
    input  logic      bvalid,
    output logic      bready,
    output data_t     res_data,
    output axi_resp_t res_resp,
    output axi_id_t   res_id,
    output logic      res_valid,
    input  logic      res_ready
);

    txn_state_e state;
    axi_ar_t    addr_q;
    axi_w_t     w_q;
    logic       aw_done;
    logic       w_done;
    logic       aw_fire;
    logic       w_fire;
    logic       accept;

    assign req_ready = (state == IDLE);
    assign accept = req_valid && req_ready;

    // ar and aw share one address register
    assign ar = addr_q;
    assign aw = addr_q;
    assign w = w_q;

    assign arvalid = (state == RD_ADDR);
    assign awvalid = (state == WR_ADDR_DATA) && !aw_done;
    assign wvalid = (state == WR_ADDR_DATA) && !w_done;
    assign rready = (state == RD_DATA) && res_ready;
    assign bready = (state == WR_RESP) && res_ready;

    assign aw_fire = awvalid && awready;
    assign w_fire = wvalid && wready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= IDLE;
            aw_done <= 1'b0;
            w_done <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    aw_done <= 1'b0;
                    w_done <= 1'b0;
                    if (accept) begin
                        state <= req.req.write ? WR_ADDR_DATA : RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (arready) begin
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (rvalid && rready) begin
                        state <= IDLE;
                    end
                end
                WR_ADDR_DATA: begin
                    if (aw_fire) begin
                        aw_done <= 1'b1;
                    end
                    if (w_fire) begin
                        w_done <= 1'b1;
                    end
                    // aw and w may finish in either order
                    if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (bvalid && bready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q.id <= req.id;
            addr_q.addr <= req.req.addr;
            addr_q.len <= AXI_LEN_SINGLE;
            addr_q.size <= req.req.size;
            addr_q.burst <= AXI_BURST_INCR;
            addr_q.cache <= AXI_CACHE_DEF;
            addr_q.prot <= AXI_PROT_DEF;
            w_q.data <= req.req.wdata;
            w_q.strb <= req.req.strb;
            w_q.last <= 1'b1;
        end
    end

    // result is taken straight from the r or b channel
    always_comb begin
        if (state == RD_DATA) begin
            res_valid = rvalid;
            res_data = r.data;
            res_resp = r.resp;
            res_id = r.id;
        end else begin
            res_valid = (state == WR_RESP) && bvalid;
            res_data = '0;
            res_resp = b.resp;
            res_id = b.id;
        end
    end

endmodule

// ==== verilog/mem_bridge_pkg.sv ====
package mem_bridge_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    // low address bits kept by the kseg mapping
    localparam int PHYS_KEEP_W = 29;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [2:0]        size_t;
    typedef logic [3:0]        axi_id_t;
    typedef logic [1:0]        axi_resp_t;
    typedef logic [7:0]        axi_len_t;
    typedef logic [1:0]        axi_burst_t;
    typedef logic [3:0]        axi_cache_t;
    typedef logic [2:0]        axi_prot_t;

    localparam axi_id_t    INST_ID        = 4'd0;
    localparam axi_id_t    DATA_ID        = 4'd1;
    localparam axi_burst_t AXI_BURST_INCR = 2'b01;
    localparam axi_len_t   AXI_LEN_SINGLE = 8'd0;
    localparam axi_cache_t AXI_CACHE_DEF  = 4'b0000;
    localparam axi_prot_t  AXI_PROT_DEF   = 3'b000;
    localparam axi_resp_t  RESP_OKAY      = 2'b00;
    localparam size_t      SIZE_WORD      = 3'd2;

    typedef struct packed {
        addr_t addr;
        logic  write;
        size_t size;
        strb_t strb;
        data_t wdata;
    } mem_req_t;

    typedef struct packed {
        data_t rdata;
        logic  err;
    } mem_rsp_t;

    // addr inside req is already physical
    typedef struct packed {
        mem_req_t req;
        axi_id_t  id;
    } dec_req_t;

    typedef struct packed {
        axi_id_t    id;
        addr_t      addr;
        axi_len_t   len;
        size_t      size;
        axi_burst_t burst;
        axi_cache_t cache;
        axi_prot_t  prot;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        data_t     data;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

    typedef enum logic [2:0] {
        IDLE,
        RD_ADDR,
        RD_DATA,
        WR_ADDR_DATA,
        WR_RESP
    } txn_state_e;

endpackage

// ==== verilog/mem_bridge_top.sv ====
`timescale 1ns/1ps

module mem_bridge_top
    import mem_bridge_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,
    input  mem_req_t inst_req,
    input  logic     inst_req_valid,
    output logic     inst_req_ready,
    output mem_rsp_t inst_rsp,
    output logic     inst_rsp_valid,
    input  logic     inst_rsp_ready,
    input  mem_req_t data_req,
    input  logic     data_req_valid,
    output logic     data_req_ready,
    output mem_rsp_t data_rsp,
    output logic     data_rsp_valid,
    input  logic     data_rsp_ready,
    output axi_ar_t  ar,
    output logic     arvalid,
    input  logic     arready,
    input  axi_r_t   r,
    input  logic     rvalid,
    output logic     rready,
    output axi_aw_t  aw,
    output logic     awvalid,
    input  logic     awready,
    output axi_w_t   w,
    output logic     wvalid,
    input  logic     wready,
    input  axi_b_t   b,
    input  logic     bvalid,
    output logic     bready
);

    dec_req_t  inst_dec;
    dec_req_t  data_dec;
    dec_req_t  grant_req;
    logic      inst_dec_valid;
    logic      inst_dec_ready;
    logic      data_dec_valid;
    logic      data_dec_ready;
    logic      grant_valid;
    logic      grant_ready;
    data_t     res_data;
    axi_resp_t res_resp;
    axi_id_t   res_id;
    logic      res_valid;
    logic      res_ready;

    req_decode #(.WRITE_EN(1'b0), .SRC_ID(INST_ID)) u_inst_decode (
        .aclk(aclk), .aresetn(aresetn),
        .req(inst_req), .req_valid(inst_req_valid), .req_ready(inst_req_ready),
        .dec(inst_dec), .dec_valid(inst_dec_valid), .dec_ready(inst_dec_ready)
    );

    req_decode #(.WRITE_EN(1'b1), .SRC_ID(DATA_ID)) u_data_decode (
        .aclk(aclk), .aresetn(aresetn),
        .req(data_req), .req_valid(data_req_valid), .req_ready(data_req_ready),
        .dec(data_dec), .dec_valid(data_dec_valid), .dec_ready(data_dec_ready)
    );

    port_arbiter u_arbiter (
        .aclk(aclk), .aresetn(aresetn),
        .inst_dec(inst_dec), .data_dec(data_dec),
        .inst_valid(inst_dec_valid), .data_valid(data_dec_valid),
        .inst_ready(inst_dec_ready), .data_ready(data_dec_ready),
        .grant_req(grant_req), .grant_valid(grant_valid), .grant_ready(grant_ready)
    );

    axi_txn_engine u_engine (
        .aclk(aclk), .aresetn(aresetn),
        .req(grant_req), .req_valid(grant_valid), .req_ready(grant_ready),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .r(r), .rvalid(rvalid), .rready(rready),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .w(w), .wvalid(wvalid), .wready(wready),
        .b(b), .bvalid(bvalid), .bready(bready),
        .res_data(res_data), .res_resp(res_resp), .res_id(res_id),
        .res_valid(res_valid), .res_ready(res_ready)
    );

    rsp_return u_return (
        .aclk(aclk), .aresetn(aresetn),
        .res_data(res_data), .res_resp(res_resp), .res_id(res_id),
        .res_valid(res_valid), .res_ready(res_ready),
        .inst_rsp(inst_rsp), .data_rsp(data_rsp),
        .inst_rsp_valid(inst_rsp_valid), .data_rsp_valid(data_rsp_valid),
        .inst_rsp_ready(inst_rsp_ready), .data_rsp_ready(data_rsp_ready)
    );

endmodule

// ==== verilog/port_arbiter.sv ====
`timescale 1ns/1ps

module port_arbiter
    import mem_bridge_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,
    input  dec_req_t inst_dec,
    input  dec_req_t data_dec,
    input  logic     inst_valid,
    input  logic     data_valid,
    output logic     inst_ready,
    output logic     data_ready,
    output dec_req_t grant_req,
    output logic     grant_valid,
    input  logic     grant_ready
);

    logic last_data;
    logic hold;
    logic hold_data;
    logic pick_data;
    logic rr_data;

    // data wins when alone or when inst went last
    assign rr_data = data_valid && (!inst_valid || !last_data);
    assign pick_data = hold ? hold_data : rr_data;

    assign grant_valid = inst_valid || data_valid;
    assign grant_req = pick_data ? data_dec : inst_dec;
    assign inst_ready = grant_ready && !pick_data;
    assign data_ready = grant_ready && pick_data;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            // so inst goes first
            last_data <= 1'b1;
            hold <= 1'b0;
            hold_data <= 1'b0;
        end else begin
            if (grant_valid && grant_ready) begin
                last_data <= pick_data;
            end
            // keep a stalled choice until it is taken
            hold <= grant_valid && !grant_ready;
            hold_data <= pick_data;
        end
    end

endmodule

// ==== verilog/req_decode.sv ====
`timescale 1ns/1ps

module req_decode
    import mem_bridge_pkg::*;
#(
    parameter bit      WRITE_EN = 1'b1,
    parameter axi_id_t SRC_ID   = DATA_ID
) (
    input  logic     aclk,
    input  logic     aresetn,
    input  mem_req_t req,
    input  logic     req_valid,
    output logic     req_ready,
    output dec_req_t dec,
    output logic     dec_valid,
    input  logic     dec_ready
);

    dec_req_t mapped;

    always_comb begin
        mapped.req = req;
        mapped.id = SRC_ID;
        // drop the segment bits
        mapped.req.addr = {{(ADDR_W-PHYS_KEEP_W){1'b0}}, req.addr[PHYS_KEEP_W-1:0]};
        if (!WRITE_EN) begin
            // fetch port is read only, always a full word
            mapped.req.write = 1'b0;
            mapped.req.strb = '0;
            mapped.req.size = SIZE_WORD;
            mapped.req.wdata = '0;
        end
    end

    assign req_ready = !dec_valid || dec_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            dec_valid <= 1'b0;
        end else if (req_valid && req_ready) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid && req_ready) begin
            dec <= mapped;
        end
    end

endmodule

// ==== verilog/rsp_return.sv ====
`timescale 1ns/1ps

module rsp_return
    import mem_bridge_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  data_t     res_data,
    input  axi_resp_t res_resp,
    input  axi_id_t   res_id,
    input  logic      res_valid,
    output logic      res_ready,
    output mem_rsp_t  inst_rsp,
    output mem_rsp_t  data_rsp,
    output logic      inst_rsp_valid,
    output logic      data_rsp_valid,
    input  logic      inst_rsp_ready,
    input  logic      data_rsp_ready
);

    mem_rsp_t rsp_q;
    axi_id_t  owner_q;
    logic     full;
    logic     owner_inst;
    logic     pop;

    assign owner_inst = (owner_q == INST_ID);

    assign inst_rsp = rsp_q;
    assign data_rsp = rsp_q;
    assign inst_rsp_valid = full && owner_inst;
    assign data_rsp_valid = full && !owner_inst;

    assign pop = full && (owner_inst ? inst_rsp_ready : data_rsp_ready);
    // refill in the same cycle the old entry leaves
    assign res_ready = !full || pop;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            full <= 1'b0;
        end else if (res_valid && res_ready) begin
            full <= 1'b1;
        end else if (pop) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (res_valid && res_ready) begin
            rsp_q.rdata <= res_data;
            rsp_q.err <= (res_resp != RESP_OKAY);
            owner_q <= res_id;
        end
    end

endmodule
